//--- Bender.yml
package:
  name: masked_a2b

sources:
  # Package first, then RTL bottom-up
  - files:
      - a2b_pkg.sv
      - masked_full_adder.sv
      - masked_a2b_conv.sv
      - mask_rng.sv
      - a2b_collect.sv
      - a2b_top.sv
  - target: test
    files:
      - tb_a2b_top.sv

//--- a2b_collect.sv
/*
 * Valid delay line and output register for all lanes
 */
`timescale 1ns/1ps

module a2b_collect
    import a2b_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         zeroize,
    input  logic                         in_valid,    // Same strobe the lanes see
    input  bool_shares_t [NUM_LANES-1:0] lane_out,
    output logic                         out_valid,   // One-cycle pulse
    output bool_shares_t [NUM_LANES-1:0] out_shares
);

    logic [A2B_LATENCY-1:0] vld_sr;  // Matches the lane pipeline depth

    // ====================
    // Delay line and output
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr     <= '0;
            out_valid  <= 1'b0;
            out_shares <= '0;
        end else if (zeroize) begin
            vld_sr     <= '0;  // Words in flight are dropped here
            out_valid  <= 1'b0;
            out_shares <= '0;
        end else begin
            vld_sr    <= {vld_sr[A2B_LATENCY-2:0], in_valid};
            out_valid <= vld_sr[A2B_LATENCY-1];
            if (vld_sr[A2B_LATENCY-1]) begin
                out_shares <= lane_out;  // Lanes are aligned in this cycle
            end
        end
    end

    a_no_valid_after_zeroize: assert property (
        @(posedge clk) disable iff (!rst_n) zeroize |=> !out_valid
    );

endmodule

//--- a2b_pkg.sv
/*
 * Shared constants and types for the masked A2B conversion
 * Word width, lane latency, share structs, per-lane randomness
 */

package a2b_pkg;

    // ====================
    // Constants
    // ====================
    localparam int A2B_WIDTH   = 8;              // Bits per secret word
    localparam int A2B_LATENCY = A2B_WIDTH + 2;  // Lane latency in cycles

    // ====================
    // Share types
    // ====================

    // One masked bit, value = sh1 ^ sh0
    typedef struct packed {
        logic sh1;
        logic sh0;
    } share_bit_t;

    // Arithmetic sharing, value = a1 + a0 mod 2^A2B_WIDTH
    typedef struct packed {
        logic [A2B_WIDTH-1:0] a1;
        logic [A2B_WIDTH-1:0] a0;
    } arith_shares_t;

    // Boolean sharing, value = b1 ^ b0
    typedef struct packed {
        logic [A2B_WIDTH-1:0] b1;
        logic [A2B_WIDTH-1:0] b0;
    } bool_shares_t;

    // Fresh randomness for one lane in one cycle
    typedef struct packed {
        logic [A2B_WIDTH-1:0] rnd_and;  // Masked AND gates of the carry chain
        logic [A2B_WIDTH-1:0] rnd_b0;   // Remask of share a0
        logic [A2B_WIDTH-1:0] rnd_b1;   // Remask of share a1
    } lane_rnd_t;

endpackage

//--- a2b_top.sv
/*
 * Masked A2B conversion subsystem
 * Mask generator, NUM_LANES conversion lanes, output collector
 */
`timescale 1ns/1ps

module a2b_top
    import a2b_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,    // Level, clears all state
    input  logic                          seed_load,
    input  logic [31:0]                   seed,
    input  logic                          in_valid,
    input  arith_shares_t [NUM_LANES-1:0] in_shares,
    output logic                          out_valid,  // A2B_LATENCY+1 after in_valid
    output bool_shares_t  [NUM_LANES-1:0] out_shares
);

    lane_rnd_t    [NUM_LANES-1:0] lane_rnd;  // Fresh masks per lane
    bool_shares_t [NUM_LANES-1:0] lane_out;  // Lane results before the collector

    mask_rng #(
        .NUM_LANES (NUM_LANES)
    ) i_mask_rng (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .seed_load (seed_load),
        .seed      (seed),
        .lane_rnd  (lane_rnd)
    );

    // ====================
    // Conversion lanes
    // ====================
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        masked_a2b_conv i_conv (
            .clk     (clk),
            .rst_n   (rst_n),
            .zeroize (zeroize),
            .x       (in_shares[l]),
            .rnd     (lane_rnd[l]),
            .s       (lane_out[l])
        );
    end

    a2b_collect #(
        .NUM_LANES (NUM_LANES)
    ) i_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .lane_out   (lane_out),
        .out_valid  (out_valid),
        .out_shares (out_shares)
    );

endmodule

//--- flist.f
a2b_pkg.sv
masked_full_adder.sv
masked_a2b_conv.sv
mask_rng.sv
a2b_collect.sv
a2b_top.sv
tb_a2b_top.sv

//--- mask_rng.sv
/*
 * Per-lane xorshift32 mask generators
 * Seed load, lane mixing, slicing into the lane randomness fields
 */
`timescale 1ns/1ps

module mask_rng
    import a2b_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      zeroize,    // Reloads from seed
    input  logic                      seed_load,  // Reloads from seed
    input  logic [31:0]               seed,
    output lane_rnd_t [NUM_LANES-1:0] lane_rnd    // New words every cycle
);

    localparam logic [31:0] RESET_SEED  = 32'h2545_F491;  // Power-up seed
    localparam logic [31:0] LANE_SPREAD = 32'h9E37_79B9;  // Golden ratio step

    logic [31:0] state_q [NUM_LANES];

    // Seed mixed with the lane index, never zero
    function automatic logic [31:0] lane_seed(input logic [31:0] base, input int lane);
        logic [31:0] mixed;
        mixed = base ^ (LANE_SPREAD * 32'(lane + 1));
        mixed = mixed ^ (mixed >> 16);
        return (mixed == '0) ? 32'h0000_0001 : mixed;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] st);
        logic [31:0] t;
        t = st ^ (st << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // ====================
    // Lane generators
    // ====================
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic [31:0] rot11;
        logic [31:0] rot22;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                state_q[l] <= lane_seed(RESET_SEED, l);
            end else if (zeroize || seed_load) begin
                state_q[l] <= lane_seed(seed, l);
            end else begin
                state_q[l] <= xorshift32(state_q[l]);  // Advance every cycle
            end
        end

        assign rot11 = {state_q[l][20:0], state_q[l][31:21]};
        assign rot22 = {state_q[l][9:0], state_q[l][31:10]};

        assign lane_rnd[l] = '{
            rnd_and: state_q[l][A2B_WIDTH-1:0],
            rnd_b0:  rot11[A2B_WIDTH-1:0],
            rnd_b1:  rot22[A2B_WIDTH-1:0]
        };

        // Xorshift locks up in the all-zero state
        a_state_nonzero: assert property (
            @(posedge clk) disable iff (!rst_n) state_q[l] != '0
        );
    end

endmodule

//--- masked_a2b_conv.sv
/*
 * One lane of arithmetic-to-Boolean share conversion
 * Remask, skew, masked ripple-carry chain, deskew
 */
`timescale 1ns/1ps

module masked_a2b_conv
    import a2b_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          zeroize,
    input  arith_shares_t x,       // Sampled every cycle
    input  lane_rnd_t     rnd,
    output bool_shares_t  s        // A2B_LATENCY cycles after x
);

    share_bit_t           carry   [A2B_WIDTH];  // carry[i] enters bit i
    share_bit_t           sum_bit [A2B_WIDTH];  // Combinational sum per bit
    logic [A2B_WIDTH-1:0] b1_w;
    logic [A2B_WIDTH-1:0] b0_w;

    assign carry[0] = '0;  // No carry into the LSB

    // ====================
    // Bit slices
    // ====================
    for (genvar i = 0; i < A2B_WIDTH; i++) begin : g_bit
        localparam int SKEW   = i + 1;              // Stages until carry i arrives
        localparam int DESKEW = A2B_WIDTH + 1 - i;  // Stages to the common output edge

        share_bit_t p_q   [SKEW];    // Boolean pair built from a0
        share_bit_t q_q   [SKEW];    // Boolean pair built from a1
        share_bit_t sum_q [DESKEW];  // Sum waiting for the higher bits

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int k = 0; k < SKEW; k++) begin
                    p_q[k] <= '0;
                    q_q[k] <= '0;
                end
                for (int k = 0; k < DESKEW; k++) begin
                    sum_q[k] <= '0;
                end
            end else if (zeroize) begin
                for (int k = 0; k < SKEW; k++) begin
                    p_q[k] <= '0;
                    q_q[k] <= '0;
                end
                for (int k = 0; k < DESKEW; k++) begin
                    sum_q[k] <= '0;
                end
            end else begin
                // Each arithmetic share becomes its own Boolean pair
                p_q[0] <= '{sh1: rnd.rnd_b0[i], sh0: x.a0[i] ^ rnd.rnd_b0[i]};
                q_q[0] <= '{sh1: rnd.rnd_b1[i], sh0: x.a1[i] ^ rnd.rnd_b1[i]};
                for (int k = 1; k < SKEW; k++) begin
                    p_q[k] <= p_q[k-1];  // Triangular skew
                    q_q[k] <= q_q[k-1];
                end
                sum_q[0] <= sum_bit[i];
                for (int k = 1; k < DESKEW; k++) begin
                    sum_q[k] <= sum_q[k-1];  // Triangular deskew
                end
            end
        end

        if (i < A2B_WIDTH - 1) begin : g_fa
            masked_full_adder i_fa (
                .clk     (clk),
                .rst_n   (rst_n),
                .zeroize (zeroize),
                .x       (p_q[SKEW-1]),
                .y       (q_q[SKEW-1]),
                .c_in    (carry[i]),
                .rnd     (rnd.rnd_and[i]),
                .s       (sum_bit[i]),
                .c_out   (carry[i+1])
            );
        end else begin : g_msb
            // Top bit has no carry out and needs XOR only
            // Spare AND bit refreshes both shares
            assign sum_bit[i] = '{
                sh1: p_q[SKEW-1].sh1 ^ q_q[SKEW-1].sh1 ^ carry[i].sh1 ^ rnd.rnd_and[i],
                sh0: p_q[SKEW-1].sh0 ^ q_q[SKEW-1].sh0 ^ carry[i].sh0 ^ rnd.rnd_and[i]
            };
        end

        assign b1_w[i] = sum_q[DESKEW-1].sh1;
        assign b0_w[i] = sum_q[DESKEW-1].sh0;
    end

    // All bits leave on the same edge
    assign s = '{b1: b1_w, b0: b0_w};

endmodule

//--- masked_full_adder.sv
/*
 * First-order masked full adder on bit share pairs
 * Combinational sum, DOM-protected majority carry with one register stage
 */
`timescale 1ns/1ps

module masked_full_adder
    import a2b_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       zeroize,   // Synchronous clear of the carry registers
    input  share_bit_t x,
    input  share_bit_t y,
    input  share_bit_t c_in,
    input  logic       rnd,       // Fresh bit for the cross-domain terms
    output share_bit_t s,
    output share_bit_t c_out      // Valid one cycle after the inputs
);

    share_bit_t u;          // x ^ c
    share_bit_t v;          // y ^ c
    logic       inner0_q;   // Domain 0 product with carry share folded in
    logic       inner1_q;   // Domain 1 product with carry share folded in
    logic       cross0_q;   // Refreshed cross term, lands in domain 0
    logic       cross1_q;   // Refreshed cross term, lands in domain 1

    // ====================
    // Sum path
    // ====================
    assign s.sh1 = x.sh1 ^ y.sh1 ^ c_in.sh1;  // Linear, share by share
    assign s.sh0 = x.sh0 ^ y.sh0 ^ c_in.sh0;

    // ====================
    // Carry path
    // ====================
    // maj(x, y, c) = ((x ^ c) & (y ^ c)) ^ c needs only one masked AND
    assign u.sh1 = x.sh1 ^ c_in.sh1;
    assign u.sh0 = x.sh0 ^ c_in.sh0;
    assign v.sh1 = y.sh1 ^ c_in.sh1;
    assign v.sh0 = y.sh0 ^ c_in.sh0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inner0_q <= 1'b0;
            inner1_q <= 1'b0;
            cross0_q <= 1'b0;
            cross1_q <= 1'b0;
        end else if (zeroize) begin
            inner0_q <= 1'b0;
            inner1_q <= 1'b0;
            cross0_q <= 1'b0;
            cross1_q <= 1'b0;
        end else begin
            inner0_q <= (u.sh0 & v.sh0) ^ c_in.sh0;
            inner1_q <= (u.sh1 & v.sh1) ^ c_in.sh1;
            cross0_q <= (u.sh0 & v.sh1) ^ rnd;  // Refreshed before it meets domain 0
            cross1_q <= (u.sh1 & v.sh0) ^ rnd;
        end
    end

    // Shares recombine only after the register stage
    assign c_out.sh0 = inner0_q ^ cross0_q;
    assign c_out.sh1 = inner1_q ^ cross1_q;

    a_carry_zeroize: assert property (
        @(posedge clk) disable iff (!rst_n) zeroize |=> (c_out == '0)
    );

endmodule

//--- tb_a2b_top.sv
/*
 * Testbench for the masked A2B subsystem
 * Clock, reset, stimulus tasks, reference sum, output checker, watchdog
 */
`timescale 1ns/1ps

module tb_a2b_top
    import a2b_pkg::*;
();

    localparam int NUM_LANES  = 4;
    localparam int N_SINGLE   = 12;               // Isolated random words
    localparam int N_BURST    = 40;               // Back-to-back words
    localparam int N_FLUSHED  = 5;                // Words killed by zeroize
    localparam int N_SEED     = 8;                // Seed comparison trials
    localparam int SINGLE_CYC = A2B_LATENCY + 3;  // One word in and its result out
    localparam int STIM_CYC   = 4 + 3 + N_SINGLE * SINGLE_CYC + N_BURST + SINGLE_CYC
                              + N_FLUSHED + 4 + SINGLE_CYC + 4 * SINGLE_CYC
                              + 2 * N_SEED * (2 + SINGLE_CYC) + SINGLE_CYC;
    localparam int TIMEOUT_CYC = STIM_CYC + A2B_LATENCY + 20;

    typedef arith_shares_t [NUM_LANES-1:0] word_t;  // One input word for all lanes

    typedef struct packed {
        word_t       shares;
        int unsigned edge_no;  // Edge on which in_valid was driven
    } pending_t;

    logic                         clk;
    logic                         rst_n;
    logic                         zeroize;
    logic                         seed_load;
    logic [31:0]                  seed;
    logic                         in_valid;
    word_t                        in_shares;
    logic                         out_valid;
    bool_shares_t [NUM_LANES-1:0] out_shares;

    pending_t                     exp_q[$];     // Words still waiting for a result
    int unsigned                  cyc = 0;      // Rising edges seen so far
    int                           errors = 0;
    int                           n_results = 0;
    bool_shares_t [NUM_LANES-1:0] last_out;     // Most recent checked output

    a2b_top #(
        .NUM_LANES (NUM_LANES)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .zeroize    (zeroize),
        .seed_load  (seed_load),
        .seed       (seed),
        .in_valid   (in_valid),
        .in_shares  (in_shares),
        .out_valid  (out_valid),
        .out_shares (out_shares)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ====================
    // Reference and stimulus helpers
    // ====================
    // Secret carried by an arithmetic sharing
    function automatic logic [A2B_WIDTH-1:0] ref_value(input arith_shares_t x);
        logic [A2B_WIDTH-1:0] sum;
        sum = x.a1 + x.a0;  // Wraps mod 2^A2B_WIDTH
        return sum;
    endfunction

    function automatic word_t random_word();
        word_t       w;
        logic [31:0] r;
        for (int l = 0; l < NUM_LANES; l++) begin
            r       = $urandom;
            w[l].a1 = r[A2B_WIDTH-1:0];
            w[l].a0 = r[2*A2B_WIDTH-1:A2B_WIDTH];
        end
        return w;
    endfunction

    // First few burst words hit the corners of the adder
    function automatic word_t edge_word(input int k);
        word_t w;
        w = random_word();
        case (k)
            0: w = '0;  // All zeros
            1: w = '1;  // All ones with a wrapping sum
            2: begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    w[l].a1 = {1'b1, {(A2B_WIDTH-1){1'b0}}};  // MSB + MSB drops the carry
                    w[l].a0 = {1'b1, {(A2B_WIDTH-1){1'b0}}};
                end
            end
            3: begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    w[l].a1 = '1;
                    w[l].a0 = A2B_WIDTH'(l + 1);  // Carry ripples through every bit
                end
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_word(input word_t w);
        pending_t p;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_shares <= w;
        p.shares  = w;
        p.edge_no = cyc + 1;  // cyc updates later in this time step
        exp_q.push_back(p);
    endtask

    task automatic go_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_results(input int target);
        wait (n_results >= target);  // Released by the output checker
    endtask

    task automatic convert_one(input word_t w);
        int target;
        target = n_results + exp_q.size() + 1;
        drive_word(w);
        go_idle();
        wait_results(target);
    endtask

    task automatic load_seed(input logic [31:0] s);
        @(posedge clk);
        seed_load <= 1'b1;
        seed      <= s;
        @(posedge clk);
        seed_load <= 1'b0;
    endtask

    // ====================
    // Output checker
    // ====================
    always @(negedge clk) begin
        pending_t             head;
        logic [A2B_WIDTH-1:0] got;
        logic [A2B_WIDTH-1:0] want;
        if (rst_n) begin
            if (out_valid) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("At time %0t out_valid pulsed with no word outstanding", $time);
                end
                if (exp_q.size() > 0) begin
                    head = exp_q.pop_front();
                    assert (cyc - head.edge_no == A2B_LATENCY + 1) else begin
                        errors++;
                        $display("Error at time %0t: out_valid latency expected %0d got %0d",
                                 $time, A2B_LATENCY + 1, cyc - head.edge_no);
                    end
                    for (int l = 0; l < NUM_LANES; l++) begin
                        got  = out_shares[l].b1 ^ out_shares[l].b0;  // Boolean recombination
                        want = ref_value(head.shares[l]);
                        assert (got == want) else begin
                            errors++;
                            $display("Error at time %0t: out_shares[%0d] b1^b0 expected %h got %h",
                                     $time, l, want, got);
                        end
                    end
                    last_out = out_shares;
                    n_results++;
                end
            end else if (n_results == 0) begin
                assert (out_shares == '0) else begin  // Quiet until the first result
                    errors++;
                    $display("Error at time %0t: out_shares expected %h got %h",
                             $time, {$bits(out_shares){1'b0}}, out_shares);
                end
            end
            if (exp_q.size() > 0) begin
                assert (cyc - exp_q[0].edge_no <= A2B_LATENCY + 1) else begin
                    errors++;
                    $display("Word driven at edge %0d got no result within %0d cycles",
                             exp_q[0].edge_no, A2B_LATENCY + 1);
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial begin
        word_t                        w;
        bool_shares_t [NUM_LANES-1:0] first_out;
        logic [31:0]                  s_a;
        int                           n_differ;
        int                           target;
        void'($urandom(76634));
        rst_n     = 1'b0;
        zeroize   = 1'b0;
        seed_load = 1'b0;
        seed      = '0;
        in_valid  = 1'b0;
        in_shares = '0;
        n_differ  = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);  // Idle outputs checked after reset

        for (int k = 0; k < N_SINGLE; k++) begin
            convert_one(random_word());
        end

        target = n_results + N_BURST;
        for (int k = 0; k < N_BURST; k++) begin
            drive_word(edge_word(k));
        end
        go_idle();
        wait_results(target);

        // Words in flight must vanish under zeroize
        for (int k = 0; k < N_FLUSHED; k++) begin
            drive_word(random_word());
        end
        @(posedge clk);
        in_valid <= 1'b0;
        zeroize  <= 1'b1;
        exp_q.delete();
        repeat (3) @(posedge clk);
        zeroize <= 1'b0;
        repeat (A2B_LATENCY + 3) @(posedge clk);  // Any out_valid here is spurious
        for (int k = 0; k < 4; k++) begin
            convert_one(random_word());
        end

        // Same secret under two seeds
        for (int k = 0; k < N_SEED; k++) begin
            w   = random_word();
            s_a = $urandom;
            load_seed(s_a);
            convert_one(w);
            first_out = last_out;
            load_seed(~s_a);
            convert_one(w);
            for (int l = 0; l < NUM_LANES; l++) begin
                if (first_out[l].b0 != last_out[l].b0) n_differ++;
            end
        end

        repeat (A2B_LATENCY + 3) @(posedge clk);
        assert (n_differ > 0) else begin
            errors++;
            $display("Share b0 never changed with the seed over %0d trials", N_SEED);
        end
        $display("Errors: %0d, results checked: %0d", errors, n_results);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cyc >= TIMEOUT_CYC);
        $display("Timeout after %0d cycles with %0d words outstanding", cyc, exp_q.size());
        $display("Errors: %0d, results checked: %0d", errors, n_results);
        $display("Test FAILED");
        $finish;
    end

endmodule
